// File: source/etx_pkg.sv
package etx_pkg;

   // one memory transaction as it moves from the clients to the link.
   typedef struct packed
   {
      logic        write;
      logic [1:0]  datamode;
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] srcaddr;
      logic [31:0] data;
   } emesh_packet_t;

   // link lane widths.
   localparam int frame_w = 8;
   localparam int beat_w  = 64;

   // frame lane codes.
   localparam logic [frame_w-1:0] frame_idle = 8'h00;
   localparam logic [frame_w-1:0] frame_head = 8'h3F;
   localparam logic [frame_w-1:0] frame_data = 8'hFF;

   // packet queue.
   localparam int fifo_depth  = 4;
   localparam int fifo_addr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

   // header beat layout, msb first:
   // zero pad, inverted write, write pad, ctrlmode, dstaddr, datamode, write, access.
   localparam int hdr_pad_w    = 16;
   localparam int hdr_wr_pad_w = 7;

   // payload beat carries data over srcaddr.
   localparam int payload_half_w = beat_w / 2;

endpackage

// File: source/etx_arbiter.sv
`timescale 1ns/100ps

module etx_arbiter
(
   input  logic                   tx_lclk_par,
   input  logic                   reset,
   input  logic                   emwr_access,
   input  etx_pkg::emesh_packet_t emwr_packet,
   input  logic                   emrd_access,
   input  etx_pkg::emesh_packet_t emrd_packet,
   output logic                   emwr_wait,
   output logic                   emrd_wait,
   output logic                   push,
   output etx_pkg::emesh_packet_t push_packet,
   input  logic                   full
);

   logic                   pend_valid;
   etx_pkg::emesh_packet_t pend_packet;
   logic                   wr_take;
   logic                   rd_take;
   logic                   pend_push;
   logic                   rd_lost;

   // both clients hold off while the queue is full or a read is parked.
   assign emwr_wait = full | pend_valid;
   assign emrd_wait = full | pend_valid;

   assign wr_take   = emwr_access & ~emwr_wait;
   assign rd_take   = emrd_access & ~emrd_wait;
   assign rd_lost   = wr_take & rd_take;  // write wins, read is parked.
   assign pend_push = pend_valid & ~full;

   // pending read first, then a new write, then a new read.
   always_comb
   begin
      push        = 1'b0;
      push_packet = emwr_packet;
      if (pend_push)
      begin
         push        = 1'b1;
         push_packet = pend_packet;
      end
      else if (wr_take)
      begin
         push        = 1'b1;
         push_packet = emwr_packet;
      end
      else if (rd_take)
      begin
         push        = 1'b1;
         push_packet = emrd_packet;
      end
   end

   always_ff @(posedge tx_lclk_par or posedge reset)
   begin
      if (reset)
      begin
         pend_valid <= 1'b0;
      end
      else if (rd_lost)
      begin
         pend_valid <= 1'b1;
      end
      else if (pend_push)
      begin
         pend_valid <= 1'b0;
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (rd_lost)
      begin
         pend_packet <= emrd_packet;
      end
   end

   // the queue full flag comes from etx_fifo.
   a_no_push_full: assert property (
      @(posedge tx_lclk_par) disable iff (reset)
      push |-> !full)
      else $error("etx_arbiter: push while queue full");

   // clients may strobe only while their wait is low.
   a_wr_strobe_wait: assert property (
      @(posedge tx_lclk_par) disable iff (reset)
      emwr_access |-> !emwr_wait)
      else $error("etx_arbiter: write strobe while emwr_wait high");

   a_rd_strobe_wait: assert property (
      @(posedge tx_lclk_par) disable iff (reset)
      emrd_access |-> !emrd_wait)
      else $error("etx_arbiter: read strobe while emrd_wait high");

endmodule

// File: source/etx_fifo.sv
`timescale 1ns/100ps

module etx_fifo
(
   input  logic                   tx_lclk_par,
   input  logic                   reset,
   input  logic                   push,
   input  etx_pkg::emesh_packet_t push_packet,
   input  logic                   pop,
   output etx_pkg::emesh_packet_t head_packet,
   output logic                   full,
   output logic                   empty
);

   localparam int aw = etx_pkg::fifo_addr_w;

   etx_pkg::emesh_packet_t mem [etx_pkg::fifo_depth];
   logic [aw-1:0]          wr_ptr;
   logic [aw-1:0]          rd_ptr;
   logic [aw:0]            count;

   // wraps at fifo_depth, so a depth that is not a power of two works too.
   function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
      logic [aw-1:0] nxt;
      if (ptr == aw'(etx_pkg::fifo_depth - 1))
      begin
         nxt = '0;
      end
      else
      begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign head_packet = mem[rd_ptr];  // show-ahead.
   assign full        = (count == (aw+1)'(etx_pkg::fifo_depth));
   assign empty       = (count == '0);

   always_ff @(posedge tx_lclk_par or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop)
         begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // none, or both at once.
         endcase
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (push)
      begin
         mem[wr_ptr] <= push_packet;
      end
   end

   a_no_pop_empty: assert property (
      @(posedge tx_lclk_par) disable iff (reset)
      pop |-> !empty)
      else $error("etx_fifo: pop while empty");

   a_no_push_full: assert property (
      @(posedge tx_lclk_par) disable iff (reset)
      push |-> !full)
      else $error("etx_fifo: push while full");

endmodule

// File: source/etx_protocol.sv
`timescale 1ns/100ps

module etx_protocol
(
   input  logic                         tx_lclk_par,
   input  logic                         reset,
   input  etx_pkg::emesh_packet_t       head_packet,
   input  logic                         empty,
   output logic                         pop,
   output logic [etx_pkg::frame_w-1:0]  tx_frame_par,
   output logic [etx_pkg::beat_w-1:0]   tx_data_par,
   input  logic                         tx_rd_wait,
   input  logic                         tx_wr_wait,
   output logic [1:0]                   ecfg_tx_datain
);

   localparam int hw = etx_pkg::payload_half_w;

   logic                        data_phase;   // payload beat is next.
   etx_pkg::emesh_packet_t      held_packet;
   logic [1:0]                  wait_meta;    // {wr, rd}.
   logic [1:0]                  wait_sync;
   logic                        head_stall;
   logic [etx_pkg::beat_w-1:0]  header_beat;
   logic [etx_pkg::beat_w-1:0]  payload_beat;

   // two-flop synchronizers for the link wait levels.
   always_ff @(posedge tx_lclk_par or posedge reset)
   begin
      if (reset)
      begin
         wait_meta <= 2'b00;
         wait_sync <= 2'b00;
      end
      else
      begin
         wait_meta <= {tx_wr_wait, tx_rd_wait};
         wait_sync <= wait_meta;
      end
   end

   assign ecfg_tx_datain = wait_sync;

   // a stalled head blocks everything behind it, keeping order.
   assign head_stall = head_packet.write ? wait_sync[1] : wait_sync[0];
   assign pop        = ~empty & ~data_phase & ~head_stall;

   assign header_beat = {
      {etx_pkg::hdr_pad_w{1'b0}},
      ~head_packet.write,
      {etx_pkg::hdr_wr_pad_w{1'b0}},
      head_packet.ctrlmode,
      head_packet.dstaddr,
      head_packet.datamode,
      head_packet.write,
      1'b1                                  // access.
   };

   assign payload_beat = {held_packet.data[hw-1:0], held_packet.srcaddr[hw-1:0]};

   always_ff @(posedge tx_lclk_par or posedge reset)
   begin
      if (reset)
      begin
         data_phase   <= 1'b0;
         tx_frame_par <= etx_pkg::frame_idle;
         tx_data_par  <= '0;
      end
      else if (pop)
      begin
         data_phase   <= 1'b1;
         tx_frame_par <= etx_pkg::frame_head;
         tx_data_par  <= header_beat;
      end
      else if (data_phase)
      begin
         // the payload goes out regardless of the wait levels.
         data_phase   <= 1'b0;
         tx_frame_par <= etx_pkg::frame_data;
         tx_data_par  <= payload_beat;
      end
      else
      begin
         tx_frame_par <= etx_pkg::frame_idle;
         tx_data_par  <= '0;
      end
   end

   always_ff @(posedge tx_lclk_par)
   begin
      if (pop)
      begin
         held_packet <= head_packet;
      end
   end

   a_head_then_data: assert property (
      @(posedge tx_lclk_par) disable iff (reset)
      (tx_frame_par == etx_pkg::frame_head) |=> (tx_frame_par == etx_pkg::frame_data))
      else $error("etx_protocol: header beat not followed by payload beat");

endmodule

// File: source/etx_top.sv
`timescale 1ns/100ps

module etx_top
(
   input  logic                         tx_lclk_par,
   input  logic                         reset,
   // write client.
   input  logic                         emwr_access,
   input  etx_pkg::emesh_packet_t       emwr_packet,
   output logic                         emwr_wait,
   // read client.
   input  logic                         emrd_access,
   input  etx_pkg::emesh_packet_t       emrd_packet,
   output logic                         emrd_wait,
   // link.
   output logic [etx_pkg::frame_w-1:0]  tx_frame_par,
   output logic [etx_pkg::beat_w-1:0]   tx_data_par,
   input  logic                         tx_rd_wait,
   input  logic                         tx_wr_wait,
   output logic [1:0]                   ecfg_tx_datain
);

   logic                   push;
   etx_pkg::emesh_packet_t push_packet;
   logic                   full;
   logic                   pop;
   etx_pkg::emesh_packet_t head_packet;
   logic                   empty;

   etx_arbiter u_arbiter
   (
      .tx_lclk_par (tx_lclk_par),
      .reset       (reset),
      .emwr_access (emwr_access),
      .emwr_packet (emwr_packet),
      .emrd_access (emrd_access),
      .emrd_packet (emrd_packet),
      .emwr_wait   (emwr_wait),
      .emrd_wait   (emrd_wait),
      .push        (push),
      .push_packet (push_packet),
      .full        (full)
   );

   etx_fifo u_fifo
   (
      .tx_lclk_par (tx_lclk_par),
      .reset       (reset),
      .push        (push),
      .push_packet (push_packet),
      .pop         (pop),
      .head_packet (head_packet),
      .full        (full),
      .empty       (empty)
   );

   etx_protocol u_protocol
   (
      .tx_lclk_par    (tx_lclk_par),
      .reset          (reset),
      .head_packet    (head_packet),
      .empty          (empty),
      .pop            (pop),
      .tx_frame_par   (tx_frame_par),
      .tx_data_par    (tx_data_par),
      .tx_rd_wait     (tx_rd_wait),
      .tx_wr_wait     (tx_wr_wait),
      .ecfg_tx_datain (ecfg_tx_datain)
   );

endmodule

// File: verification/etx_tb_checks.svh
function automatic logic [63:0] header_of(input etx_pkg::emesh_packet_t p);
   return {16'h0000, ~p.write, 7'h00, p.ctrlmode, p.dstaddr, p.datamode, p.write, 1'b1};
endfunction

function automatic logic [63:0] payload_of(input etx_pkg::emesh_packet_t p);
   return {p.data, p.srcaddr};
endfunction

task automatic report_value(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
   $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
   stop_run();
endtask

task automatic report_failure(input string what);
   $display("Error at %0t: %s", $time, what);
   stop_run();
endtask

// a beat on the lane belongs to the oldest accepted packet.
task automatic check_beat();
   if (tx_frame_par == etx_pkg::frame_head || tx_frame_par == etx_pkg::frame_data)
   begin
      if (sb_q.size() == 0)
      begin
         report_failure("a packet beat appeared with no accepted packet left to send");
      end
      else if (tx_frame_par == etx_pkg::frame_head)
      begin
         assert (tx_data_par === header_of(sb_q[0]))
            else report_value("tx_data_par", header_of(sb_q[0]), tx_data_par);
      end
      else
      begin
         assert (tx_data_par === payload_of(sb_q[0]))
            else report_value("tx_data_par", payload_of(sb_q[0]), tx_data_par);
         void'(sb_q.pop_front());
      end
   end
endtask

task automatic wait_clients_ready(input int limit);
   for (int n = 0; n < limit && (emwr_wait || emrd_wait); n++)
   begin
      step_cycle();
   end
   if (emwr_wait || emrd_wait)
   begin
      report_failure("the client waits never went low");
   end
endtask

task automatic wait_sync_level(input int idx, input logic level, input int limit);
   for (int n = 0; n < limit && ecfg_tx_datain[idx] !== level; n++)
   begin
      step_cycle();
   end
   if (ecfg_tx_datain[idx] !== level)
   begin
      report_failure("the synchronized link wait never reached the driven level");
   end
endtask

task automatic wait_drain(input int limit);
   for (int n = 0; n < limit && sb_q.size() != 0; n++)
   begin
      step_cycle();
   end
   if (sb_q.size() != 0)
   begin
      report_failure("accepted packets never left on the link");
   end
endtask

// strobe writes until the queue pushes back.
task automatic fill_queue(input int limit);
   wr_accepted = 0;
   for (int n = 0; n < limit && !emwr_wait; n++)
   begin
      emwr_access = 1'b1;
      emwr_packet = random_packet(1'b1);
      step_cycle();
   end
   emwr_access = 1'b0;
   if (!emwr_wait)
   begin
      report_failure("emwr_wait never rose while the write link was stalled");
   end
   assert (wr_accepted <= etx_pkg::fifo_depth + 1)
      else report_value("wr_accepted", etx_pkg::fifo_depth + 1, wr_accepted);
endtask

a_rst_frame: assert property (@(posedge tx_lclk_par)
   (reset || $fell(reset)) |-> tx_frame_par == etx_pkg::frame_idle)
   else report_value("tx_frame_par", etx_pkg::frame_idle, $sampled(tx_frame_par));

a_rst_data: assert property (@(posedge tx_lclk_par)
   (reset || $fell(reset)) |-> tx_data_par == '0)
   else report_value("tx_data_par", '0, $sampled(tx_data_par));

a_rst_waits: assert property (@(posedge tx_lclk_par)
   (reset || $fell(reset)) |-> {emwr_wait, emrd_wait, ecfg_tx_datain} == 4'b0000)
   else report_value("emwr_wait, emrd_wait, ecfg_tx_datain", '0,
                     $sampled({emwr_wait, emrd_wait, ecfg_tx_datain}));

a_head_data: assert property (@(posedge tx_lclk_par) disable iff (reset)
   tx_frame_par == etx_pkg::frame_head |=> tx_frame_par == etx_pkg::frame_data)
   else report_value("tx_frame_par", etx_pkg::frame_data, $sampled(tx_frame_par));

a_frame_code: assert property (@(posedge tx_lclk_par) disable iff (reset)
   tx_frame_par == etx_pkg::frame_idle || tx_frame_par == etx_pkg::frame_head ||
   tx_frame_par == etx_pkg::frame_data)
   else report_failure("tx_frame_par shows a code that is not idle, header or payload");

a_idle_zero: assert property (@(posedge tx_lclk_par) disable iff (reset)
   tx_frame_par == etx_pkg::frame_idle |-> tx_data_par == '0)
   else report_value("tx_data_par", '0, $sampled(tx_data_par));

a_wait_sync: assert property (@(posedge tx_lclk_par) disable iff (reset)
   ecfg_tx_datain == link_wait_d2)
   else report_value("ecfg_tx_datain", $sampled(link_wait_d2), $sampled(ecfg_tx_datain));

// bit 1 of the header beat is the write flag.
a_wr_stall: assert property (@(posedge tx_lclk_par) disable iff (reset)
   (tx_frame_par == etx_pkg::frame_head && tx_data_par[1]) |-> !ecfg_d1[1])
   else report_failure("a write header started while the write wait was high");

a_rd_stall: assert property (@(posedge tx_lclk_par) disable iff (reset)
   (tx_frame_par == etx_pkg::frame_head && !tx_data_par[1]) |-> !ecfg_d1[0])
   else report_failure("a read header started while the read wait was high");

// File: verification/etx_tb.sv
`timescale 1ns/100ps

module etx_tb;

   localparam int random_cycles = 300;
   localparam int drain_limit   = 200;

   logic                   tx_lclk_par;
   logic                   reset;
   logic                   emwr_access;
   etx_pkg::emesh_packet_t emwr_packet;
   logic                   emwr_wait;
   logic                   emrd_access;
   etx_pkg::emesh_packet_t emrd_packet;
   logic                   emrd_wait;
   logic [7:0]             tx_frame_par;
   logic [63:0]            tx_data_par;
   logic                   tx_rd_wait;
   logic                   tx_wr_wait;
   logic [1:0]             ecfg_tx_datain;

   logic [15:0]            lfsr;
   etx_pkg::emesh_packet_t sb_q [$];  // packets accepted but not yet seen on the link.
   int                     wr_accepted;
   logic [1:0]             link_wait_d1;
   logic [1:0]             link_wait_d2;
   logic [1:0]             ecfg_d1;

   etx_top dut
   (
      .tx_lclk_par    (tx_lclk_par),
      .reset          (reset),
      .emwr_access    (emwr_access),
      .emwr_packet    (emwr_packet),
      .emwr_wait      (emwr_wait),
      .emrd_access    (emrd_access),
      .emrd_packet    (emrd_packet),
      .emrd_wait      (emrd_wait),
      .tx_frame_par   (tx_frame_par),
      .tx_data_par    (tx_data_par),
      .tx_rd_wait     (tx_rd_wait),
      .tx_wr_wait     (tx_wr_wait),
      .ecfg_tx_datain (ecfg_tx_datain)
   );

   `include "etx_tb_checks.svh"

   always #10 tx_lclk_par = ~tx_lclk_par;

   task automatic stop_run();
      $display("Checks failed");
      $fatal(1, "stopped at the first error");
   endtask

   // x^16 + x^15 + x^13 + x^4 + 1.
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[15]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic etx_pkg::emesh_packet_t random_packet(input logic wr);
      etx_pkg::emesh_packet_t p;
      p.write    = wr;
      p.datamode = 2'(rand_bits(2));
      p.ctrlmode = 4'(rand_bits(4));
      p.dstaddr  = rand_bits(32);
      p.srcaddr  = rand_bits(32);
      p.data     = rand_bits(32);
      return p;
   endfunction

   task automatic step_cycle();
      @(posedge tx_lclk_par);
      #1;
   endtask

   // link wait levels two edges back, and the status one edge back.
   always @(posedge tx_lclk_par or posedge reset)
   begin
      if (reset)
      begin
         link_wait_d1 <= 2'b00;
         link_wait_d2 <= 2'b00;
         ecfg_d1      <= 2'b00;
      end
      else
      begin
         link_wait_d1 <= {tx_wr_wait, tx_rd_wait};
         link_wait_d2 <= link_wait_d1;
         ecfg_d1      <= ecfg_tx_datain;
      end
   end

   always @(posedge tx_lclk_par)
   begin
      if (!reset)
      begin
         check_beat();
         if (emwr_access && !emwr_wait)
         begin
            sb_q.push_back(emwr_packet);  // write ahead of a read in the same cycle.
            wr_accepted++;
         end
         if (emrd_access && !emrd_wait)
         begin
            sb_q.push_back(emrd_packet);
         end
      end
   end

   initial
   begin
      tx_lclk_par = 1'b0;
      reset       = 1'b1;
      emwr_access = 1'b0;
      emwr_packet = '0;
      emrd_access = 1'b0;
      emrd_packet = '0;
      tx_rd_wait  = 1'b0;
      tx_wr_wait  = 1'b0;
      lfsr        = 16'd73;
      wr_accepted = 0;
      repeat (16) @(posedge tx_lclk_par);
      #1;
      reset = 1'b0;

      // both clients at once.
      wait_clients_ready(20);
      emwr_access = 1'b1;
      emwr_packet = random_packet(1'b1);
      emrd_access = 1'b1;
      emrd_packet = random_packet(1'b0);
      step_cycle();
      emwr_access = 1'b0;
      emrd_access = 1'b0;
      wait_drain(drain_limit);

      for (int n = 0; n < random_cycles; n++)
      begin
         emwr_access = rand_bits(1) && !emwr_wait;
         emwr_packet = random_packet(1'b1);
         emrd_access = rand_bits(1) && !emrd_wait;
         emrd_packet = random_packet(1'b0);
         if (rand_bits(3) == 0)
         begin
            tx_wr_wait = ~tx_wr_wait;
         end
         if (rand_bits(3) == 0)
         begin
            tx_rd_wait = ~tx_rd_wait;
         end
         step_cycle();
      end
      emwr_access = 1'b0;
      emrd_access = 1'b0;
      tx_wr_wait  = 1'b0;
      tx_rd_wait  = 1'b0;
      wait_drain(drain_limit);

      // stalled write link fills the queue.
      tx_wr_wait = 1'b1;
      wait_sync_level(1, 1'b1, 10);
      fill_queue(20);
      repeat (8) step_cycle();
      tx_wr_wait = 1'b0;
      wait_drain(drain_limit);

      $display("All checks passed");
      $finish;
   end

endmodule

// File: sim.f
+incdir+verification
source/etx_pkg.sv
source/etx_arbiter.sv
source/etx_fifo.sv
source/etx_protocol.sv
source/etx_top.sv
verification/etx_tb.sv
